/* datapath_trace.txt */
// control  memoryData  flag  expectedBus
// flag 0 = no check, 1 = compare busValue, 2 = end of trace
00000000 00000000 1 00000000
00000100 00000000 1 00000000
00000200 00000000 1 00000000
00000300 00000000 1 00000000
00000400 00000000 1 00000000
00000500 00000000 1 00000000
00000600 00000000 1 00000000
00000700 00000000 1 00000000
00000800 00000000 1 00000000
00000900 00000000 1 00000000
00000A00 00000000 1 00000000
00000B00 00000000 1 00000000
00000C00 00000000 1 00000000
00000D00 00000000 1 00000000
00000E00 00000000 1 00000000
00000F00 00000000 1 00000000
00001000 00000000 1 00000000
00001100 00000000 1 00000000
00001200 00000000 1 00000000
00001300 00000000 1 00000000
00001400 00000000 1 00000000
00001500 00000000 1 00000000
00001600 00000000 1 00000000
02200000 00000011 1 00000000
00861500 00000000 1 00000011
02200300 00000002 1 00000011
008E1500 00000000 1 00000002
20000300 00000000 1 00000011
1000E700 00000000 1 00000002
00001300 00000000 1 00000044
10000700 00000000 1 00000002
00001300 00000000 1 00000013
10002700 00000000 1 00000002
00001300 00000000 1 0000000F
10004700 00000000 1 00000002
00001300 00000000 1 00000000
10006700 00000000 1 00000002
00001300 00000000 1 00000013
10008700 00000000 1 00000002
00001300 00000000 1 00000004
10010700 00000000 1 00000002
00001300 00000000 1 40000004
10012700 00000000 1 00000002
00001300 00000000 1 00000044
10014700 00000000 1 00000002
00001300 00000000 1 FFFFFFFE
10016700 00000000 1 00000002
00001300 00000000 1 FFFFFFFD
00001200 00000000 1 FFFFFFFF
02200000 9A812345 0 00000000
40001500 00000000 1 9A812345
00001600 00000000 1 00012345
02200000 5C7C0ABC 0 00000000
40001500 00000000 1 5C7C0ABC
20001600 00000000 1 FFFC0ABC
1000A700 00000000 1 00000002
00001300 00000000 1 FFFF02AF
02200000 00010001 0 00000000
00821500 00000000 1 00010001
10018100 00000000 1 00010001
08001200 00000000 1 FFFFFFFC
04001300 00000000 1 0AB80ABC
00001000 00000000 1 FFFFFFFC
00001100 00000000 1 0AB80ABC
1001A300 00000000 1 00000011
08001200 00000000 1 FFFFFFF6
04001300 00000000 1 FFFFC466
00001000 00000000 1 FFFFFFF6
00001100 00000000 1 FFFFC466
80001500 00000000 1 00010001
10401400 00000000 1 00010001
80001300 00000000 1 00010002
01001400 00000000 1 00010002
00001700 00000000 1 00000000
00000000 00000000 2 00000000

/* vlog.f */
datapathPkg.sv
registerBank.sv
specialRegisters.sv
aluUnit.sv
busMultiplexer.sv
datapath.sv
datapath_assert.sv
datapath_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	--top-module datapath_tb -f vlog.f -o datapath_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/datapath_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

/* datapath_tb.sv */
`timescale 1ns/100ps
module datapath_tb;
	import datapathPkg::*;

	localparam int dataWidth = 32;
	localparam int maxRecords = 128;
	localparam int resetCycles = 4;
	localparam int checkDelay = 4;     // Sample 1 ns before the rising edge

	// One cycle of stimulus and its expected bus value
	typedef struct packed {
		controlWordT control;
		logic [31:0] memoryData;
		logic [3:0] flag;
		logic [31:0] expected;
	} traceRecordT;

	logic clock;
	logic reset;
	controlWordT control;
	logic [dataWidth-1:0] memoryData;
	logic [dataWidth-1:0] busValue;
	logic [dataWidth-1:0] marValue;
	logic [dataWidth-1:0] irValue;

	logic [31:0] traceWords [4*maxRecords];  // Four words per trace line
	traceRecordT records [maxRecords];
	int recordCount;
	int cycleCount = 0;
	int cycleLimit = maxRecords + resetCycles + 20;
	logic [31:0] expectedMar;                // Bus value of the last MAR load
	logic [31:0] expectedIr;                 // Bus value of the last IR load

	datapath #(.dataWidth(dataWidth)) datapath_inst (
		.clock(clock),
		.reset(reset),
		.control(control),
		.memoryData(memoryData),
		.busValue(busValue),
		.marValue(marValue),
		.irValue(irValue)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Ends the run if the trace does not finish in time
	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("timeout: the trace did not finish within %0d cycles", cycleLimit);
			$display("Result: FAILED");
			$fatal(1, "Run timed out");
		end
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected, input int index);
		if (actual !== expected) begin
			$display("error: %s is %h, expected %h (record %0d)", name, actual, expected, index);
			$display("Result: FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	initial begin
		int i;
		control = '0;
		memoryData = '0;
		reset = 1'b1;
		expectedMar = '0;
		expectedIr = '0;

		$readmemh("datapath_trace.txt", traceWords);
		for (i = 0; i < maxRecords; i++) begin
			records[i] = {traceWords[4*i], traceWords[4*i+1], traceWords[4*i+2][3:0],
				traceWords[4*i+3]};
		end

		// First record with flag 2 marks the end of the trace
		recordCount = -1;
		for (i = 0; i < maxRecords; i++) begin
			if (recordCount < 0 && records[i].flag == 4'h2) begin
				recordCount = i;
			end
		end
		if (recordCount < 1) begin
			$display("trace file has no records or no end marker");
			$display("Result: FAILED");
			$fatal(1, "Bad trace file");
		end
		cycleLimit = recordCount + resetCycles + 20;

		// MAR and IR expectations come from the bus value of their load cycle
		for (i = 0; i < recordCount; i++) begin
			if ((records[i].control.loadMar || records[i].control.loadIr)
				&& records[i].flag != 4'h1) begin
				$display("trace record %0d loads MAR or IR without an expected bus value", i);
				$display("Result: FAILED");
				$fatal(1, "Bad trace file");
			end
		end

		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		for (i = 0; i < recordCount; i++) begin
			control = records[i].control;       // Applied on the falling edge
			memoryData = records[i].memoryData;
			#checkDelay;
			if (records[i].flag == 4'h1) begin
				checkValue("busValue", busValue, records[i].expected, i);
			end
			checkValue("marValue", marValue, expectedMar, i);
			checkValue("irValue", irValue, expectedIr, i);
			if (records[i].control.loadMar) begin
				expectedMar = records[i].expected;  // Visible after the coming edge
			end
			if (records[i].control.loadIr) begin
				expectedIr = records[i].expected;
			end
			@(negedge clock);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

/* datapath_assert.sv */
`timescale 1ns/100ps
module datapath_assert #(
	parameter int dataWidth = 32
) (
	input logic clock,
	input logic reset,
	input datapathPkg::controlWordT control,
	input logic [dataWidth-1:0] bus,
	input logic [dataWidth-1:0] memoryData,
	input logic [dataWidth-1:0] marValue,
	input logic [dataWidth-1:0] mdrValue,
	input logic [dataWidth-1:0] pcValue
);

	marLoad: assert property (@(posedge clock) disable iff (reset)
		control.loadMar |=> marValue == $past(bus))
		else $error("MAR does not hold the bus value of the load cycle");

	// Memory read path bypasses the bus
	mdrRead: assert property (@(posedge clock) disable iff (reset)
		(control.mdrRead && control.loadMdr) |=> mdrValue == $past(memoryData))
		else $error("MDR does not hold the memory data of the read cycle");

	pcLoad: assert property (@(posedge clock) disable iff (reset)
		control.loadPc |=> pcValue == $past(bus))
		else $error("PC does not hold the bus value of the load cycle");

endmodule

bind specialRegisters datapath_assert #(.dataWidth(dataWidth)) datapath_assert_inst (
	.clock(clock),
	.reset(reset),
	.control(control),
	.bus(bus),
	.memoryData(memoryData),
	.marValue(marValue),
	.mdrValue(mdrValue),
	.pcValue(pcValue)
);

/* datapath.sv */
`timescale 1ns/100ps
module datapath #(
	parameter int dataWidth = 32
) (
	input logic clock,
	input logic reset,
	input datapathPkg::controlWordT control,
	input logic [dataWidth-1:0] memoryData,
	output logic [dataWidth-1:0] busValue,
	output logic [dataWidth-1:0] marValue,
	output logic [dataWidth-1:0] irValue
);
	import datapathPkg::*;

	logic [dataWidth-1:0] bus;
	logic [dataWidth-1:0] gpValues [16];
	logic [dataWidth-1:0] pcValue;
	logic [dataWidth-1:0] mdrValue;
	logic [dataWidth-1:0] yValue;
	logic [dataWidth-1:0] hiValue;
	logic [dataWidth-1:0] loValue;
	zWordT zValue;

	assign busValue = bus;

	registerBank #(.dataWidth(dataWidth)) registerBank_inst (
		.clock(clock),
		.reset(reset),
		.control(control),
		.bus(bus),
		.gpValues(gpValues)
	);

	specialRegisters #(.dataWidth(dataWidth)) specialRegisters_inst (
		.clock(clock),
		.reset(reset),
		.control(control),
		.bus(bus),
		.memoryData(memoryData),
		.pcValue(pcValue),
		.irValue(irValue),
		.marValue(marValue),
		.mdrValue(mdrValue),
		.yValue(yValue),
		.hiValue(hiValue),
		.loValue(loValue)
	);

	aluUnit #(.dataWidth(dataWidth)) aluUnit_inst (
		.clock(clock),
		.reset(reset),
		.control(control),
		.bus(bus),
		.yValue(yValue),       // Operand A
		.zValue(zValue)
	);

	// Single driver of the shared bus
	busMultiplexer #(.dataWidth(dataWidth)) busMultiplexer_inst (
		.busSelect(control.busSelect),
		.gpValues(gpValues),
		.pcValue(pcValue),
		.irValue(irValue),
		.mdrValue(mdrValue),
		.hiValue(hiValue),
		.loValue(loValue),
		.zValue(zValue),
		.bus(bus)
	);

endmodule

/* busMultiplexer.sv */
`timescale 1ns/100ps
module busMultiplexer #(
	parameter int dataWidth = 32
) (
	input datapathPkg::busSourceT busSelect,
	input logic [dataWidth-1:0] gpValues [16],
	input logic [dataWidth-1:0] pcValue,
	input logic [dataWidth-1:0] irValue,
	input logic [dataWidth-1:0] mdrValue,
	input logic [dataWidth-1:0] hiValue,
	input logic [dataWidth-1:0] loValue,
	input datapathPkg::zWordT zValue,
	output logic [dataWidth-1:0] bus
);
	import datapathPkg::*;

	instructionT instruction;
	logic [dataWidth-1:0] immediate;

	assign instruction = irValue;

	// Immediate field sign-extended to a full word
	assign immediate = {{(dataWidth-19){instruction.immediateFormat.constant[18]}},
		instruction.immediateFormat.constant};

	always_comb begin
		bus = '0;
		if (!busSelect[4]) begin
			bus = gpValues[busSelect[3:0]];  // Codes 0 to 15
		end else begin
			case (busSelect)
				busHi: bus = hiValue;
				busLo: bus = loValue;
				busZHigh: bus = zValue.high;
				busZLow: bus = zValue.low;
				busPc: bus = pcValue;
				busMdr: bus = mdrValue;
				busC: bus = immediate;
				default: bus = '0;           // Undefined codes
			endcase
		end
	end

endmodule

/* aluUnit.sv */
`timescale 1ns/100ps
module aluUnit #(
	parameter int dataWidth = 32
) (
	input logic clock,
	input logic reset,
	input datapathPkg::controlWordT control,
	input logic [dataWidth-1:0] bus,
	input logic [dataWidth-1:0] yValue,
	output datapathPkg::zWordT zValue
);
	import datapathPkg::*;

	logic signed [dataWidth-1:0] operandA;
	logic signed [dataWidth-1:0] operandB;
	logic signed [2*dataWidth-1:0] wideA;
	logic signed [2*dataWidth-1:0] wideB;
	logic [4:0] amount;
	logic [dataWidth-1:0] lowResult;
	logic [2*dataWidth-1:0] result;

	assign operandA = yValue;
	assign operandB = bus;
	assign wideA = operandA;        // Sign-extended for the full product
	assign wideB = operandB;
	assign amount = bus[4:0];       // Shift and rotate distance

	// Single-word operations
	always_comb begin
		lowResult = '0;
		if (control.incPc) begin
			lowResult = bus + 1'b1;     // Overrides aluOp
		end else begin
			case (control.aluOp)
				aluAdd: lowResult = operandA + operandB;
				aluSub: lowResult = operandA - operandB;
				aluAnd: lowResult = operandA & operandB;
				aluOr: lowResult = operandA | operandB;
				aluShr: lowResult = operandA >> amount;
				aluShra: lowResult = operandA >>> amount;
				aluShl, aluSll: lowResult = operandA << amount;
				aluRor: lowResult = (operandA >> amount) | (operandA << (dataWidth - amount));
				aluRol: lowResult = (operandA << amount) | (operandA >> (dataWidth - amount));
				aluNeg: lowResult = -operandB;
				aluNot: lowResult = ~operandB;
				default: lowResult = '0;
			endcase
		end
	end

	// Multiply and divide fill both halves, the rest sign-extend
	always_comb begin
		result = {{dataWidth{lowResult[dataWidth-1]}}, lowResult};
		if (!control.incPc) begin
			if (control.aluOp == aluMul) begin
				result = wideA * wideB;
			end else if (control.aluOp == aluDiv) begin
				if (operandB == '0) begin
					result = '0;          // Divide by zero gives zero
				end else begin
					result = {operandA % operandB, operandA / operandB};
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			zValue <= '0;
		end else if (control.loadZ) begin
			zValue.high <= result[2*dataWidth-1:dataWidth];
			zValue.low  <= result[dataWidth-1:0];
		end
	end

endmodule

/* specialRegisters.sv */
`timescale 1ns/100ps
module specialRegisters #(
	parameter int dataWidth = 32
) (
	input logic clock,
	input logic reset,
	input datapathPkg::controlWordT control,
	input logic [dataWidth-1:0] bus,
	input logic [dataWidth-1:0] memoryData,
	output logic [dataWidth-1:0] pcValue,
	output logic [dataWidth-1:0] irValue,
	output logic [dataWidth-1:0] marValue,
	output logic [dataWidth-1:0] mdrValue,
	output logic [dataWidth-1:0] yValue,
	output logic [dataWidth-1:0] hiValue,
	output logic [dataWidth-1:0] loValue
);

	logic [dataWidth-1:0] mdrInput;

	// MDR takes memory data on a read, the bus otherwise
	assign mdrInput = control.mdrRead ? memoryData : bus;

	always_ff @(posedge clock) begin
		if (reset) begin
			pcValue  <= '0;
			irValue  <= '0;
			marValue <= '0;
			mdrValue <= '0;
			yValue   <= '0;
			hiValue  <= '0;
			loValue  <= '0;
		end else begin
			if (control.loadPc) begin
				pcValue <= bus;
			end
			if (control.loadIr) begin
				irValue <= bus;
			end
			if (control.loadMar) begin
				marValue <= bus;  // Address toward memory
			end
			if (control.loadMdr) begin
				mdrValue <= mdrInput;
			end
			if (control.loadY) begin
				yValue <= bus;    // Holds ALU operand A
			end
			if (control.loadHi) begin
				hiValue <= bus;
			end
			if (control.loadLo) begin
				loValue <= bus;
			end
		end
	end

endmodule

/* registerBank.sv */
`timescale 1ns/100ps
module registerBank #(
	parameter int dataWidth = 32
) (
	input logic clock,
	input logic reset,
	input datapathPkg::controlWordT control,
	input logic [dataWidth-1:0] bus,
	output logic [dataWidth-1:0] gpValues [16]
);

	logic [15:0] writeSelect;

	// One-hot write decode from the address field
	always_comb begin
		writeSelect = '0;
		if (control.loadGp) begin
			writeSelect[control.gpAddress] = 1'b1;
		end
	end

	genvar i;
	generate
		for (i = 0; i < 16; i++) begin : gpRegister
			always_ff @(posedge clock) begin
				if (reset) begin
					gpValues[i] <= '0;
				end else if (writeSelect[i]) begin
					gpValues[i] <= bus;  // Load from the bus at the edge
				end
			end
		end
	endgenerate

endmodule

/* datapathPkg.sv */
package datapathPkg;

	// What drives the bus in a given cycle
	typedef enum logic [4:0] {
		busR[0:15],          // General registers R0 to R15, codes 0 to 15
		busHi    = 5'd16,
		busLo    = 5'd17,
		busZHigh = 5'd18,
		busZLow  = 5'd19,
		busPc    = 5'd20,
		busMdr   = 5'd21,
		busC     = 5'd22     // Sign-extended immediate from IR
	} busSourceT;

	typedef enum logic [3:0] {
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluAnd  = 4'd2,
		aluOr   = 4'd3,
		aluShr  = 4'd4,
		aluShra = 4'd5,
		aluShl  = 4'd6,
		aluSll  = 4'd7,      // Same behavior as aluShl
		aluRor  = 4'd8,
		aluRol  = 4'd9,
		aluNeg  = 4'd10,
		aluNot  = 4'd11,
		aluMul  = 4'd12,
		aluDiv  = 4'd13
	} aluOpT;

	// One cycle of control from the external sequencer
	typedef struct packed {
		logic loadPc;
		logic loadIr;
		logic loadY;
		logic loadZ;
		logic loadHi;
		logic loadLo;
		logic loadMdr;
		logic loadMar;
		logic loadGp;
		logic incPc;         // ALU computes bus plus one
		logic mdrRead;       // MDR takes memory data instead of bus
		logic [3:0] gpAddress;
		aluOpT aluOp;
		busSourceT busSelect;
		logic [7:0] spare;
	} controlWordT;

	// IR contents seen as register format or immediate format
	typedef union packed {
		struct packed {
			logic [4:0] opcode;
			logic [3:0] ra;
			logic [3:0] rb;
			logic [3:0] rc;
			logic [14:0] unused;
		} registerFormat;
		struct packed {
			logic [4:0] opcode;
			logic [3:0] ra;
			logic [3:0] rb;
			logic [18:0] constant;
		} immediateFormat;
	} instructionT;

	typedef struct packed {
		logic [31:0] high;
		logic [31:0] low;
	} zWordT;

endpackage
